// File: hdl/regmap_pkg.sv
`default_nettype none

package regmap_pkg;

	// Register word and pointer widths
	localparam int data_w = 32;
	localparam int ptr_w = 5;

	// System register numbers
	localparam logic [ptr_w-1:0] sysreg_psr = 5'd0;
	localparam logic [ptr_w-1:0] sysreg_spr = 5'd3;
	localparam logic [ptr_w-1:0] sysreg_pdtr = 5'd4;
	localparam logic [ptr_w-1:0] sysreg_kpdtr = 5'd5;
	localparam logic [ptr_w-1:0] sysreg_tidr = 5'd6;

	// Free-run counter halves
	localparam logic [ptr_w-1:0] sysreg_frclr = 5'd8;
	localparam logic [ptr_w-1:0] sysreg_frchr = 5'd9;

	// Destination of a full 64-bit counter write
	localparam logic [ptr_w-1:0] sysreg_frcr2frcxr = 5'd10;

endpackage

`default_nettype wire

// File: hdl/wb_pkg.sv
`default_nettype none

package wb_pkg;

	import regmap_pkg::*;

	// 64-bit counter word, stored whole, read back by halves
	typedef union packed {
		logic [2*data_w-1:0] full;
		struct packed {
			logic [data_w-1:0] hi;
			logic [data_w-1:0] lo;
		} half;
	} frcr_word_t;

endpackage

`default_nettype wire

// File: hdl/gr_file.sv
`timescale 1ns/1ps
`default_nettype none

module gr_file
	import regmap_pkg::*;
(
	input wire iCLOCK,
	input wire rst,
	// Read port
	input wire [ptr_w-1:0] rd_pointer,
	output logic [data_w-1:0] rd_data,
	// Commit write port
	input wire wr_valid,
	input wire [ptr_w-1:0] wr_pointer,
	input wire [data_w-1:0] wr_data
);

	localparam int depth = 1 << ptr_w;

	logic [data_w-1:0] regs [0:depth-1];

	// Whole file starts from zero
	always_ff @(posedge iCLOCK) begin
		if (rst) begin
			for (int i = 0; i < depth; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_valid) begin
			regs[wr_pointer] <= wr_data;
		end
	end

	// Asynchronous read, forwarding covers in-flight writes
	assign rd_data = regs[rd_pointer];

endmodule

`default_nettype wire

// File: hdl/sysreg_file.sv
`timescale 1ns/1ps
`default_nettype none

module sysreg_file
	import regmap_pkg::*;
	import wb_pkg::*;
(
	input wire iCLOCK,
	input wire rst,
	// Read by system register number
	input wire [ptr_w-1:0] rd_pointer,
	output logic [data_w-1:0] rd_data,
	// Numbered commit write
	input wire wr_valid,
	input wire [ptr_w-1:0] wr_pointer,
	input wire [data_w-1:0] wr_data,
	// Dedicated SPR write
	input wire spr_wr_valid,
	input wire [data_w-1:0] spr_wr_data,
	// Full counter write
	input wire frcr_wr_valid,
	input wire frcr_word_t frcr_wr_data,
	// Raw control registers
	output logic [data_w-1:0] spr,
	output logic [data_w-1:0] psr,
	output logic [data_w-1:0] pdtr,
	output logic [data_w-1:0] kpdtr,
	output logic [data_w-1:0] tidr
);

	frcr_word_t frcr;

	always_ff @(posedge iCLOCK) begin
		if (rst) begin
			spr <= '0;
			psr <= '0;
			pdtr <= '0;
			kpdtr <= '0;
			tidr <= '0;
			frcr <= '0;
		end else begin
			if (wr_valid) begin
				case (wr_pointer)
					sysreg_psr: psr <= wr_data;
					sysreg_spr: spr <= wr_data;
					sysreg_pdtr: pdtr <= wr_data;
					sysreg_kpdtr: kpdtr <= wr_data;
					sysreg_tidr: tidr <= wr_data;
					default: begin
					end
				endcase
			end
			// Dedicated port has the last word on SPR
			if (spr_wr_valid) begin
				spr <= spr_wr_data;
			end
			if (frcr_wr_valid) begin
				frcr <= frcr_wr_data;
			end
		end
	end

	// Numbered read, counter split into halves
	always_comb begin
		case (rd_pointer)
			sysreg_psr: rd_data = psr;
			sysreg_spr: rd_data = spr;
			sysreg_pdtr: rd_data = pdtr;
			sysreg_kpdtr: rd_data = kpdtr;
			sysreg_tidr: rd_data = tidr;
			sysreg_frclr: rd_data = frcr.half.lo;
			sysreg_frchr: rd_data = frcr.half.hi;
			default: rd_data = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/writeback_history.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_history
	import regmap_pkg::*;
	import wb_pkg::*;
(
	input wire iCLOCK,
	input wire rst,
	// Incoming writeback
	input wire wb_valid,
	input wire [ptr_w-1:0] wb_dest,
	input wire wb_dest_sysreg,
	input wire [data_w-1:0] wb_data,
	input wire wb_spr_valid,
	input wire [data_w-1:0] wb_spr_data,
	input wire wb_frcr_valid,
	input wire frcr_word_t wb_frcr_data,
	// Current slot, one cycle old
	output logic cur_gr_valid,
	output logic [ptr_w-1:0] cur_gr_dest,
	output logic cur_gr_dest_sysreg,
	output logic [data_w-1:0] cur_gr_data,
	output logic cur_spr_valid,
	output logic [data_w-1:0] cur_spr_data,
	output logic cur_frcr_valid,
	output frcr_word_t cur_frcr_data,
	// Previous slot, two cycles old
	output logic prev_gr_valid,
	output logic [ptr_w-1:0] prev_gr_dest,
	output logic prev_gr_dest_sysreg,
	output logic [data_w-1:0] prev_gr_data,
	output logic prev_spr_valid,
	output logic [data_w-1:0] prev_spr_data,
	output logic prev_frcr_valid,
	output frcr_word_t prev_frcr_data,
	// Commit to the register files
	output logic commit_gr_valid,
	output logic [ptr_w-1:0] commit_gr_dest,
	output logic commit_gr_dest_sysreg,
	output logic [data_w-1:0] commit_gr_data,
	output logic commit_spr_valid,
	output logic [data_w-1:0] commit_spr_data,
	output logic commit_frcr_valid,
	output frcr_word_t commit_frcr_data
);

	// Two-deep shift, the older slot ages out into the files
	always_ff @(posedge iCLOCK) begin
		if (rst) begin
			{cur_gr_valid, cur_gr_dest, cur_gr_dest_sysreg, cur_gr_data} <= '0;
			{cur_spr_valid, cur_spr_data, cur_frcr_valid, cur_frcr_data} <= '0;
			{prev_gr_valid, prev_gr_dest, prev_gr_dest_sysreg, prev_gr_data} <= '0;
			{prev_spr_valid, prev_spr_data, prev_frcr_valid, prev_frcr_data} <= '0;
		end else begin
			cur_gr_valid <= wb_valid;
			cur_gr_dest <= wb_dest;
			cur_gr_dest_sysreg <= wb_dest_sysreg;
			cur_gr_data <= wb_data;
			cur_spr_valid <= wb_spr_valid;
			cur_spr_data <= wb_spr_data;
			cur_frcr_valid <= wb_frcr_valid;
			cur_frcr_data <= wb_frcr_data;
			prev_gr_valid <= cur_gr_valid;
			prev_gr_dest <= cur_gr_dest;
			prev_gr_dest_sysreg <= cur_gr_dest_sysreg;
			prev_gr_data <= cur_gr_data;
			prev_spr_valid <= cur_spr_valid;
			prev_spr_data <= cur_spr_data;
			prev_frcr_valid <= cur_frcr_valid;
			prev_frcr_data <= cur_frcr_data;
		end
	end

	// Previous slot lands in the files at the next edge
	assign commit_gr_valid = prev_gr_valid;
	assign commit_gr_dest = prev_gr_dest;
	assign commit_gr_dest_sysreg = prev_gr_dest_sysreg;
	assign commit_gr_data = prev_gr_data;
	assign commit_spr_valid = prev_spr_valid;
	assign commit_spr_data = prev_spr_data;
	assign commit_frcr_valid = prev_frcr_valid;
	assign commit_frcr_data = prev_frcr_data;

endmodule

`default_nettype wire

// File: hdl/execute_forwarding.sv
`timescale 1ns/1ps
`default_nettype none

module execute_forwarding
	import regmap_pkg::*;
	import wb_pkg::*;
(
	// Source request and raw file values
	input wire src_sysreg,
	input wire [ptr_w-1:0] src_pointer,
	input wire src_imm,
	input wire [data_w-1:0] src_data,
	input wire [data_w-1:0] src_spr,
	input wire [data_w-1:0] src_pdtr,
	input wire [data_w-1:0] src_kpdtr,
	input wire [data_w-1:0] src_tidr,
	input wire [data_w-1:0] src_psr,
	// Current slot
	input wire cur_gr_valid,
	input wire [ptr_w-1:0] cur_gr_dest,
	input wire cur_gr_dest_sysreg,
	input wire [data_w-1:0] cur_gr_data,
	input wire cur_spr_valid,
	input wire [data_w-1:0] cur_spr_data,
	input wire cur_frcr_valid,
	input wire frcr_word_t cur_frcr_data,
	// Previous slot
	input wire prev_gr_valid,
	input wire [ptr_w-1:0] prev_gr_dest,
	input wire prev_gr_dest_sysreg,
	input wire [data_w-1:0] prev_gr_data,
	input wire prev_spr_valid,
	input wire [data_w-1:0] prev_spr_data,
	input wire prev_frcr_valid,
	input wire frcr_word_t prev_frcr_data,
	// Rewritten values
	output logic [data_w-1:0] next_data,
	output logic [data_w-1:0] next_spr,
	output logic [data_w-1:0] next_pdtr,
	output logic [data_w-1:0] next_kpdtr,
	output logic [data_w-1:0] next_tidr,
	output logic [data_w-1:0] next_psr
);

	// Control registers that a numbered system write reaches
	function automatic logic is_ctrl(input logic [ptr_w-1:0] pointer);
		return pointer == sysreg_psr || pointer == sysreg_pdtr ||
			pointer == sysreg_kpdtr || pointer == sysreg_tidr;
	endfunction

	// One forwarding step of the source operand against one slot
	function automatic logic [data_w-1:0] rewrite_src(
		input logic [data_w-1:0] data,
		input logic sysreg,
		input logic [ptr_w-1:0] pointer,
		input logic imm,
		input logic gr_valid,
		input logic gr_sysreg,
		input logic [ptr_w-1:0] gr_dest,
		input logic [data_w-1:0] gr_data,
		input logic spr_hit,
		input logic [data_w-1:0] spr_val,
		input logic frcr_valid,
		input frcr_word_t frcr_data
	);
		if (imm) begin
			return data;
		end
		if (sysreg) begin
			if (pointer == sysreg_spr && spr_hit) begin
				return spr_val;
			end
			if (pointer == sysreg_frclr && frcr_valid) begin
				return frcr_data.half.lo;
			end
			if (pointer == sysreg_frchr && frcr_valid) begin
				return frcr_data.half.hi;
			end
			if (is_ctrl(pointer) && gr_valid && gr_sysreg && gr_dest == pointer) begin
				return gr_data;
			end
		end else if (gr_valid && !gr_sysreg && gr_dest == pointer) begin
			return gr_data;
		end
		return data;
	endfunction

	// One forwarding step of a single control register
	function automatic logic [data_w-1:0] rewrite_ctrl(
		input logic [ptr_w-1:0] target,
		input logic [data_w-1:0] data,
		input logic gr_valid,
		input logic gr_sysreg,
		input logic [ptr_w-1:0] gr_dest,
		input logic [data_w-1:0] gr_data
	);
		if (gr_valid && gr_sysreg && gr_dest == target) begin
			return gr_data;
		end
		return data;
	endfunction

	logic cur_spr_hit;
	logic prev_spr_hit;
	logic [data_w-1:0] cur_spr_val;
	logic [data_w-1:0] prev_spr_val;
	logic [data_w-1:0] prev_step_data;

	// A slot touches SPR by the dedicated port or a numbered write
	// Dedicated port wins, as in the file
	assign cur_spr_hit = cur_spr_valid ||
		(cur_gr_valid && cur_gr_dest_sysreg && cur_gr_dest == sysreg_spr);
	assign prev_spr_hit = prev_spr_valid ||
		(prev_gr_valid && prev_gr_dest_sysreg && prev_gr_dest == sysreg_spr);
	assign cur_spr_val = cur_spr_valid ? cur_spr_data : cur_gr_data;
	assign prev_spr_val = prev_spr_valid ? prev_spr_data : prev_gr_data;

	// Older slot first so the newest write wins
	assign prev_step_data = rewrite_src(src_data, src_sysreg, src_pointer, src_imm,
		prev_gr_valid, prev_gr_dest_sysreg, prev_gr_dest, prev_gr_data,
		prev_spr_hit, prev_spr_val, prev_frcr_valid, prev_frcr_data);
	assign next_data = rewrite_src(prev_step_data, src_sysreg, src_pointer, src_imm,
		cur_gr_valid, cur_gr_dest_sysreg, cur_gr_dest, cur_gr_data,
		cur_spr_hit, cur_spr_val, cur_frcr_valid, cur_frcr_data);

	assign next_spr = cur_spr_hit ? cur_spr_val : (prev_spr_hit ? prev_spr_val : src_spr);

	// Control registers, previous writeback then current
	assign next_pdtr = rewrite_ctrl(sysreg_pdtr,
		rewrite_ctrl(sysreg_pdtr, src_pdtr,
			prev_gr_valid, prev_gr_dest_sysreg, prev_gr_dest, prev_gr_data),
		cur_gr_valid, cur_gr_dest_sysreg, cur_gr_dest, cur_gr_data);
	assign next_kpdtr = rewrite_ctrl(sysreg_kpdtr,
		rewrite_ctrl(sysreg_kpdtr, src_kpdtr,
			prev_gr_valid, prev_gr_dest_sysreg, prev_gr_dest, prev_gr_data),
		cur_gr_valid, cur_gr_dest_sysreg, cur_gr_dest, cur_gr_data);
	assign next_tidr = rewrite_ctrl(sysreg_tidr,
		rewrite_ctrl(sysreg_tidr, src_tidr,
			prev_gr_valid, prev_gr_dest_sysreg, prev_gr_dest, prev_gr_data),
		cur_gr_valid, cur_gr_dest_sysreg, cur_gr_dest, cur_gr_data);
	assign next_psr = rewrite_ctrl(sysreg_psr,
		rewrite_ctrl(sysreg_psr, src_psr,
			prev_gr_valid, prev_gr_dest_sysreg, prev_gr_dest, prev_gr_data),
		cur_gr_valid, cur_gr_dest_sysreg, cur_gr_dest, cur_gr_data);

endmodule

`default_nettype wire

// File: hdl/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stage
	import regmap_pkg::*;
	import wb_pkg::*;
(
	input wire iCLOCK,
	input wire rst,
	// Writeback
	input wire wb_valid,
	input wire [ptr_w-1:0] wb_dest,
	input wire wb_dest_sysreg,
	input wire [data_w-1:0] wb_data,
	input wire wb_spr_valid,
	input wire [data_w-1:0] wb_spr_data,
	input wire wb_frcr_valid,
	input wire frcr_word_t wb_frcr_data,
	// Operand request
	input wire src_valid,
	input wire [ptr_w-1:0] src_pointer,
	input wire src_sysreg,
	input wire src_imm,
	input wire [data_w-1:0] src_imm_data,
	// Operands, one cycle after the request
	output logic op_valid,
	output logic [data_w-1:0] op_data,
	output logic [data_w-1:0] op_spr,
	output logic [data_w-1:0] op_pdtr,
	output logic [data_w-1:0] op_kpdtr,
	output logic [data_w-1:0] op_tidr,
	output logic [data_w-1:0] op_psr
);

	logic cur_gr_valid, cur_gr_dest_sysreg, cur_spr_valid, cur_frcr_valid;
	logic [ptr_w-1:0] cur_gr_dest;
	logic [data_w-1:0] cur_gr_data, cur_spr_data;
	frcr_word_t cur_frcr_data;
	logic prev_gr_valid, prev_gr_dest_sysreg, prev_spr_valid, prev_frcr_valid;
	logic [ptr_w-1:0] prev_gr_dest;
	logic [data_w-1:0] prev_gr_data, prev_spr_data;
	frcr_word_t prev_frcr_data;
	logic commit_gr_valid, commit_gr_dest_sysreg, commit_spr_valid, commit_frcr_valid;
	logic [ptr_w-1:0] commit_gr_dest;
	logic [data_w-1:0] commit_gr_data, commit_spr_data;
	frcr_word_t commit_frcr_data;

	logic [data_w-1:0] gr_rd_data, sys_rd_data, file_data;
	logic [data_w-1:0] raw_spr, raw_psr, raw_pdtr, raw_kpdtr, raw_tidr;
	logic [data_w-1:0] next_data, next_spr, next_pdtr, next_kpdtr, next_tidr, next_psr;

	writeback_history history_i (.*);

	// Numbered commits split between the two files
	gr_file gr_file_i (
		.iCLOCK(iCLOCK), .rst(rst),
		.rd_pointer(src_pointer), .rd_data(gr_rd_data),
		.wr_valid(commit_gr_valid && !commit_gr_dest_sysreg),
		.wr_pointer(commit_gr_dest), .wr_data(commit_gr_data)
	);

	sysreg_file sysreg_file_i (
		.iCLOCK(iCLOCK), .rst(rst),
		.rd_pointer(src_pointer), .rd_data(sys_rd_data),
		.wr_valid(commit_gr_valid && commit_gr_dest_sysreg),
		.wr_pointer(commit_gr_dest), .wr_data(commit_gr_data),
		.spr_wr_valid(commit_spr_valid), .spr_wr_data(commit_spr_data),
		.frcr_wr_valid(commit_frcr_valid), .frcr_wr_data(commit_frcr_data),
		.spr(raw_spr), .psr(raw_psr), .pdtr(raw_pdtr), .kpdtr(raw_kpdtr), .tidr(raw_tidr)
	);

	// Immediate bypasses both files
	assign file_data = src_imm ? src_imm_data : (src_sysreg ? sys_rd_data : gr_rd_data);

	execute_forwarding forwarding_i (
		.src_data(file_data), .src_spr(raw_spr), .src_pdtr(raw_pdtr),
		.src_kpdtr(raw_kpdtr), .src_tidr(raw_tidr), .src_psr(raw_psr),
		.*
	);

	always_ff @(posedge iCLOCK) begin
		if (rst) begin
			op_valid <= 1'b0;
			{op_data, op_spr, op_pdtr, op_kpdtr, op_tidr, op_psr} <= '0;
		end else begin
			op_valid <= src_valid;
			if (src_valid) begin
				op_data <= next_data;
				op_spr <= next_spr;
				op_pdtr <= next_pdtr;
				op_kpdtr <= next_kpdtr;
				op_tidr <= next_tidr;
				op_psr <= next_psr;
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/operand_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stage_sva
	import regmap_pkg::*;
(
	input wire iCLOCK,
	input wire rst,
	input wire src_valid,
	input wire src_imm,
	input wire [data_w-1:0] src_imm_data,
	input wire op_valid,
	input wire [data_w-1:0] op_data
);

	// Fixed one-cycle latency, the strobe mirrors the request
	valid_follows_request: assert property (@(posedge iCLOCK)
		!$past(rst) |-> op_valid == $past(src_valid))
		else $error("op_valid differs from src_valid of the previous cycle");

	// Reset clears the strobe
	valid_low_after_reset: assert property (@(posedge iCLOCK)
		$past(rst) |-> !op_valid)
		else $error("op_valid high in the cycle after reset");

	// Immediates are never rewritten by forwarding
	imm_passes_through: assert property (@(posedge iCLOCK)
		!$past(rst) && $past(src_valid && src_imm) |-> op_data == $past(src_imm_data))
		else $error("op_data differs from the immediate of the previous request");

endmodule

bind operand_stage operand_stage_sva sva_i (
	.iCLOCK(iCLOCK),
	.rst(rst),
	.src_valid(src_valid),
	.src_imm(src_imm),
	.src_imm_data(src_imm_data),
	.op_valid(op_valid),
	.op_data(op_data)
);

`default_nettype wire

// File: sim/operand_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stage_tb
	import regmap_pkg::*;
();

	// One table row per cycle
	// Expected values belong to the previous row's request
	typedef struct packed {
		logic [2:0] grp;
		logic wb_valid;
		logic [ptr_w-1:0] wb_dest;
		logic wb_sys;
		logic [data_w-1:0] wb_data;
		logic spr_valid;
		logic [data_w-1:0] spr_data;
		logic frcr_valid;
		logic [2*data_w-1:0] frcr_data;
		logic src_valid;
		logic [ptr_w-1:0] src_pointer;
		logic src_sys;
		logic src_imm;
		logic [data_w-1:0] imm_data;
		logic chk;
		logic [data_w-1:0] e_data, e_spr, e_pdtr, e_kpdtr, e_tidr, e_psr;
	} row_t;

	logic iCLOCK;
	logic rst;
	logic wb_valid;
	logic [ptr_w-1:0] wb_dest;
	logic wb_dest_sysreg;
	logic [data_w-1:0] wb_data;
	logic wb_spr_valid;
	logic [data_w-1:0] wb_spr_data;
	logic wb_frcr_valid;
	logic [2*data_w-1:0] wb_frcr_data;
	logic src_valid;
	logic [ptr_w-1:0] src_pointer;
	logic src_sysreg;
	logic src_imm;
	logic [data_w-1:0] src_imm_data;
	logic op_valid;
	logic [data_w-1:0] op_data, op_spr, op_pdtr, op_kpdtr, op_tidr, op_psr;

	row_t rows [$];
	int n_rows = 0;
	int cur_grp = 0;
	int checks = 0;
	int errors = 0;
	int grp_checks [6];
	int grp_errors [6];
	string grp_names [6] = '{"reset", "gr_forwarding", "immediate", "spr", "frcr", "ctrl"};

	operand_stage operand_stage_i (.*);

	initial iCLOCK = 1'b0;
	always #50 iCLOCK = ~iCLOCK;

	task automatic add_row(input row_t r);
		rows.push_back(r);
	endtask

	// Row columns in order
	// grp | wb v,dest,sys,data | spr v,data | frcr v,data |
	// req v,ptr,sys,imm,imm_data | chk,data,spr,pdtr,kpdtr,tidr,psr
	task automatic load_table();
		add_row(row_t'{0, 0,0,0,0, 0,0, 0,0, 1,5,0,0,0, 0,0,0,0,0,0,0});
		add_row(row_t'{0, 0,0,0,0, 0,0, 0,0, 1,3,1,0,0, 1,0,0,0,0,0,0});
		add_row(row_t'{0, 0,0,0,0, 0,0, 0,0, 1,0,1,0,0, 1,0,0,0,0,0,0});
		// R7 written three times and then read at growing distance
		add_row(row_t'{1, 1,7,0,'h11, 0,0, 0,0, 1,7,0,0,0, 1,0,0,0,0,0,0});
		add_row(row_t'{1, 1,7,0,'h22, 0,0, 0,0, 1,7,0,0,0, 1,0,0,0,0,0,0});
		add_row(row_t'{1, 1,7,0,'h33, 0,0, 0,0, 1,7,0,0,0, 1,'h11,0,0,0,0,0});
		add_row(row_t'{1, 0,0,0,0, 0,0, 0,0, 1,7,0,0,0, 1,'h22,0,0,0,0,0});
		add_row(row_t'{1, 1,8,0,'ha8, 0,0, 0,0, 1,7,0,0,0, 1,'h33,0,0,0,0,0});
		add_row(row_t'{1, 1,9,0,'ha9, 0,0, 0,0, 1,7,0,0,0, 1,'h33,0,0,0,0,0});
		add_row(row_t'{1, 1,10,0,'haa, 0,0, 0,0, 1,8,0,0,0, 1,'h33,0,0,0,0,0});
		add_row(row_t'{1, 0,0,0,0, 0,0, 0,0, 1,9,0,0,0, 1,'ha8,0,0,0,0,0});
		add_row(row_t'{1, 0,0,0,0, 0,0, 0,0, 1,10,0,0,0, 1,'ha9,0,0,0,0,0});
		// Immediate on a pointer with a write in flight
		add_row(row_t'{2, 1,12,0,'hc0, 0,0, 0,0, 1,12,0,1,'h55, 1,'haa,0,0,0,0,0});
		add_row(row_t'{2, 0,0,0,0, 0,0, 0,0, 1,12,0,1,'h66, 1,'h55,0,0,0,0,0});
		add_row(row_t'{2, 0,0,0,0, 0,0, 0,0, 1,12,0,0,0, 1,'h66,0,0,0,0,0});
		// SPR by both paths with the dedicated port winning in row 18
		add_row(row_t'{3, 0,0,0,0, 1,'h1000, 0,0, 1,3,1,0,0, 1,'hc0,0,0,0,0,0});
		add_row(row_t'{3, 1,3,1,'h2000, 0,0, 0,0, 1,3,1,0,0, 1,0,0,0,0,0,0});
		add_row(row_t'{3, 0,0,0,0, 0,0, 0,0, 1,3,1,0,0, 1,'h1000,'h1000,0,0,0,0});
		add_row(row_t'{3, 1,3,1,'h4000, 1,'h3000, 0,0, 1,3,1,0,0, 1,'h2000,'h2000,0,0,0,0});
		add_row(row_t'{3, 0,0,0,0, 0,0, 0,0, 1,3,0,0,0, 1,'h2000,'h2000,0,0,0,0});
		add_row(row_t'{3, 0,0,0,0, 0,0, 0,0, 1,3,1,0,0, 1,0,'h3000,0,0,0,0});
		add_row(row_t'{3, 0,0,0,0, 0,0, 0,0, 1,3,1,0,0, 1,'h3000,'h3000,0,0,0,0});
		// Counter halves at distances 1 to 4
		add_row(row_t'{4, 0,0,0,0, 0,0, 1,64'h89ab_cdef_0123_4567,
			1,8,1,0,0, 1,'h3000,'h3000,0,0,0,0});
		add_row(row_t'{4, 0,0,0,0, 0,0, 0,0, 1,8,1,0,0, 1,0,'h3000,0,0,0,0});
		add_row(row_t'{4, 0,0,0,0, 0,0, 0,0, 1,9,1,0,0, 1,'h0123_4567,'h3000,0,0,0,0});
		add_row(row_t'{4, 0,0,0,0, 0,0, 0,0, 1,8,1,0,0, 1,'h89ab_cdef,'h3000,0,0,0,0});
		add_row(row_t'{4, 0,0,0,0, 0,0, 0,0, 1,9,1,0,0, 1,'h0123_4567,'h3000,0,0,0,0});
		add_row(row_t'{4, 0,0,0,0, 0,0, 1,64'hfedc_ba98_7654_3210,
			1,9,1,0,0, 1,'h89ab_cdef,'h3000,0,0,0,0});
		// PDTR, KPDTR, TIDR and PSR read back in flight, then general writes to R4 and R0
		add_row(row_t'{5, 1,4,1,'hd4, 0,0, 0,0, 1,9,1,0,0, 1,'h89ab_cdef,'h3000,0,0,0,0});
		add_row(row_t'{5, 1,5,1,'hd5, 0,0, 0,0, 1,8,1,0,0, 1,'hfedc_ba98,'h3000,0,0,0,0});
		add_row(row_t'{5, 1,6,1,'hd6, 0,0, 0,0, 1,4,1,0,0, 1,'h7654_3210,'h3000,'hd4,0,0,0});
		add_row(row_t'{5, 1,0,1,'hd0, 0,0, 0,0, 1,6,1,0,0, 1,'hd4,'h3000,'hd4,'hd5,0,0});
		add_row(row_t'{5, 1,4,0,'he4, 0,0, 0,0, 1,4,1,0,0, 1,'hd6,'h3000,'hd4,'hd5,'hd6,0});
		add_row(row_t'{5, 1,0,0,'he0, 0,0, 0,0, 1,4,0,0,0, 1,'hd4,'h3000,'hd4,'hd5,'hd6,'hd0});
		add_row(row_t'{5, 0,0,0,0, 0,0, 0,0, 1,0,1,0,0, 1,'he4,'h3000,'hd4,'hd5,'hd6,'hd0});
		add_row(row_t'{5, 0,0,0,0, 0,0, 0,0, 0,0,0,0,0, 1,'hd0,'h3000,'hd4,'hd5,'hd6,'hd0});
		add_row(row_t'{5, 0,0,0,0, 0,0, 0,0, 0,0,0,0,0, 0,0,0,0,0,0,0});
	endtask

	task automatic drive_row(input row_t r);
		wb_valid = r.wb_valid;
		wb_dest = r.wb_dest;
		wb_dest_sysreg = r.wb_sys;
		wb_data = r.wb_data;
		wb_spr_valid = r.spr_valid;
		wb_spr_data = r.spr_data;
		wb_frcr_valid = r.frcr_valid;
		wb_frcr_data = r.frcr_data;
		src_valid = r.src_valid;
		src_pointer = r.src_pointer;
		src_sysreg = r.src_sys;
		src_imm = r.src_imm;
		src_imm_data = r.imm_data;
	endtask

	task automatic check_val(input string name, input logic [data_w-1:0] got,
		input logic [data_w-1:0] exp);
		checks++;
		grp_checks[cur_grp]++;
		if (got !== exp) begin
			$display("CHECK FAILED at %t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
			grp_errors[cur_grp]++;
		end
	endtask

	task automatic check_row(input int i);
		logic exp_valid;
		exp_valid = (i > 0) ? rows[i-1].src_valid : 1'b0;
		check_val("op_valid", 32'(op_valid), 32'(exp_valid));
		if (rows[i].chk) begin
			check_val("op_data", op_data, rows[i].e_data);
			check_val("op_spr", op_spr, rows[i].e_spr);
			check_val("op_pdtr", op_pdtr, rows[i].e_pdtr);
			check_val("op_kpdtr", op_kpdtr, rows[i].e_kpdtr);
			check_val("op_tidr", op_tidr, rows[i].e_tidr);
			check_val("op_psr", op_psr, rows[i].e_psr);
		end
	endtask

	task automatic report_group(input int g);
		$display("Test %s finished: %0d checks, %0d errors", grp_names[g], grp_checks[g],
			grp_errors[g]);
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		rst = 1'b1;
		drive_row('0);
		load_table();
		n_rows = rows.size();
		repeat (2) @(posedge iCLOCK);
		#5;
		rst = 1'b0;
		for (int i = 0; i < n_rows; i++) begin
			if (i > 0) begin
				@(posedge iCLOCK);
				#5;
			end
			// A check belongs to the test of the request it looks at
			cur_grp = (i > 0) ? int'(rows[i-1].grp) : int'(rows[0].grp);
			check_row(i);
			if (i > 0 && rows[i].grp != rows[i-1].grp) begin
				report_group(cur_grp);
			end
			drive_row(rows[i]);
		end
		@(posedge iCLOCK);
		#5;
		report_group(int'(rows[n_rows-1].grp));
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		wait (n_rows > 0);
		#((n_rows + 10) * 100);
		$display("Timeout: %0d table rows did not finish within %0d clock cycles", n_rows,
			n_rows + 10);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
hdl/regmap_pkg.sv
hdl/wb_pkg.sv
hdl/gr_file.sv
hdl/sysreg_file.sv
hdl/writeback_history.sv
hdl/execute_forwarding.sv
hdl/operand_stage.sv
sim/operand_stage_sva.sv
sim/operand_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the operand stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module operand_stage_tb -f compile.f \
	--Mdir obj_dir -o operand_stage_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
	cat "$build_log"
	echo "Build failed, see $build_log"
	exit 1
fi

./obj_dir/operand_stage_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$sim_log"; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" "$sim_log"; then
	echo "No result line found in $sim_log"
	exit 1
fi
exit 0
